// File: common/alu_pkg.sv
// Shared definitions for the 16-bit execute-stage ALU
// Opcodes C to F are not in the enum and are treated as invalid by the merge block
// Widths are fixed by the teaching CPU. Changing data_w also changes the saturation limits

package alu_pkg;

  //////////////////////////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////////////////////////
  localparam int op_w    = 4;   // Opcode field
  localparam int data_w  = 16;  // Operand and result width
  localparam int shamt_w = 4;   // Shift and rotate amount, taken from b
  localparam int byte_w  = 8;   // Byte lanes for RED, LLB and LHB
  localparam int nib_w   = 4;   // Nibble lanes for PADDSB

  // Signed saturation limits for ADD/SUB
  localparam logic [data_w-1:0] sat_max = {1'b0, {(data_w-1){1'b1}}};  // 7FFF
  localparam logic [data_w-1:0] sat_min = {1'b1, {(data_w-1){1'b0}}};  // 8000

  //////////////////////////////////////////////////////////////////////
  // Opcodes
  //////////////////////////////////////////////////////////////////////
  // Encoding follows the CPU ISA. Codes C..F are left unused
  typedef enum logic [op_w-1:0] {
    op_add    = 4'h0,  // Saturating add
    op_sub    = 4'h1,  // Saturating subtract
    op_xor    = 4'h2,
    op_red    = 4'h3,  // Reduction add of four signed bytes
    op_sll    = 4'h4,
    op_sra    = 4'h5,
    op_ror    = 4'h6,
    op_paddsb = 4'h7,  // Four parallel saturating nibble adds
    op_lw     = 4'h8,  // Address formation, wraps
    op_sw     = 4'h9,  // Same address formation as LW
    op_llb    = 4'hA,  // Load low byte
    op_lhb    = 4'hB   // Load high byte
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////
  // Request bundle
  //////////////////////////////////////////////////////////////////////
  // One request, as fanned out by the top level to both units
  typedef struct packed {
    alu_op_e           op;
    logic [data_w-1:0] a;  // Operand A, also the base for LW/SW
    logic [data_w-1:0] b;  // Operand B, low bits give the shift amount
  } alu_req_s;

endpackage

// File: common/flag_pkg.sv
// Condition flags and unit result types for the execute-stage ALU
// Flag write rule: ADD/SUB write Z, V and N; XOR and the shifts write Z only
// Every other opcode, the invalid ones included, leaves the flags alone

package flag_pkg;

  import alu_pkg::*;

  // Condition flags as seen by a branch unit
  typedef struct packed {
    logic z;  // Result was zero
    logic v;  // Signed overflow, saturated
    logic n;  // Result sign bit
  } alu_flags_s;

  // Which flags an opcode may write
  typedef enum logic [1:0] {
    fc_none   = 2'd0,
    fc_z_only = 2'd1,
    fc_zvn    = 2'd2
  } flag_class_e;

  // Output of one functional unit
  typedef struct packed {
    logic [data_w-1:0] value;
    logic              ovf;    // Only the arithmetic unit raises this
  } unit_res_s;

  // Opcode to flag write class
  function automatic flag_class_e flag_class_of(input alu_op_e op);
    flag_class_e fc;
    case (op)
      op_add, op_sub:                 fc = fc_zvn;
      op_xor, op_sll, op_sra, op_ror: fc = fc_z_only;
      default:                        fc = fc_none;  // Also C..F
    endcase
    return fc;
  endfunction

endpackage

// File: source/arith_unit.sv
// Arithmetic unit, purely combinational
// ADD/SUB saturate to 7FFF or 8000 on signed overflow and raise ovf
// LW/SW form a + (b << 1) with bit 0 of a cleared, wrap silently, never raise ovf
// All other opcodes give zero

`timescale 1ns/10ps

module arith_unit
  import alu_pkg::*;
  import flag_pkg::*;
(
  input  alu_req_s  req,
  output unit_res_s res
);

  logic [data_w-1:0] sum;      // Raw a + b
  logic [data_w-1:0] diff;     // Raw a - b
  logic [data_w-1:0] addr_a;   // Halfword-aligned base
  logic [data_w-1:0] addr_b;   // Offset in halfwords
  logic              add_ovf;
  logic              sub_ovf;
  logic              a_neg;

  //////////////////////////////////////////////////////////////////////
  // Raw sums and overflow detection
  //////////////////////////////////////////////////////////////////////
  assign sum  = req.a + req.b;
  assign diff = req.a - req.b;
  assign a_neg = req.a[data_w-1];

  // Overflow when operand signs match and the sum sign flips
  assign add_ovf = (a_neg == req.b[data_w-1]) && (sum[data_w-1] != a_neg);
  // Overflow when operand signs differ and the result sign leaves that of a
  assign sub_ovf = (a_neg != req.b[data_w-1]) && (diff[data_w-1] != a_neg);

  // LW/SW operand shaping
  assign addr_a  = {req.a[data_w-1:1], 1'b0};   // Clear bit 0
  assign addr_b  = {req.b[data_w-2:0], 1'b0};   // Word offset to byte offset

  // Overflow direction follows the sign of a for both add and subtract
  function automatic logic [data_w-1:0] saturate(
    input logic [data_w-1:0] raw,
    input logic              ovf,
    input logic              neg
  );
    if (!ovf)
      return raw;
    return neg ? sat_min : sat_max;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    res = '0;  // Non-arithmetic opcodes
    case (req.op)
      op_add: begin
        res.value = saturate(sum, add_ovf, a_neg);
        res.ovf   = add_ovf;
      end
      op_sub: begin
        res.value = saturate(diff, sub_ovf, a_neg);
        res.ovf   = sub_ovf;
      end
      op_lw, op_sw: begin
        res.value = addr_a + addr_b;  // Wraps without saturation
      end
      default: begin
        res = '0;
      end
    endcase
  end

endmodule

// File: source/logic_shift_unit.sv
// Logic, shift and byte unit, purely combinational
// Shift and rotate amounts come from b[3:0], so shifts of 0..15 only
// RED sums four signed bytes, result sign-extended from the true sum
// PADDSB lanes saturate independently to -8..+7. ovf is always low

`timescale 1ns/10ps

module logic_shift_unit
  import alu_pkg::*;
  import flag_pkg::*;
(
  input  alu_req_s  req,
  output unit_res_s res
);

  logic [shamt_w-1:0]  shamt;      // Shift or rotate amount
  logic [data_w-1:0]   xor_val;
  logic [data_w-1:0]   red_val;
  logic [data_w-1:0]   sll_val;
  logic [data_w-1:0]   sra_val;
  logic [2*data_w-1:0] ror_wide;   // Two copies of a, shifted right
  logic [data_w-1:0]   paddsb_val;
  logic [data_w-1:0]   llb_val;
  logic [data_w-1:0]   lhb_val;

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////
  function automatic logic [data_w-1:0] sext_byte(input logic [byte_w-1:0] v);
    return {{(data_w-byte_w){v[byte_w-1]}}, v};
  endfunction

  // Lane-wise signed nibble add with saturation
  function automatic logic [data_w-1:0] nibble_sat_add(
    input logic [data_w-1:0] x,
    input logic [data_w-1:0] y
  );
    logic [data_w-1:0] acc;
    logic [nib_w:0]    s;       // One guard bit for the lane
    acc = '0;
    for (int i = 0; i < data_w / nib_w; i++) begin
      s = {x[i*nib_w+nib_w-1], x[i*nib_w +: nib_w]}
        + {y[i*nib_w+nib_w-1], y[i*nib_w +: nib_w]};
      if (s[nib_w] != s[nib_w-1]) begin
        // Guard bit gives the true sign
        acc[i*nib_w +: nib_w] = s[nib_w] ? {1'b1, {(nib_w-1){1'b0}}}   // -8
                                         : {1'b0, {(nib_w-1){1'b1}}};  // +7
      end else begin
        acc[i*nib_w +: nib_w] = s[nib_w-1:0];
      end
    end
    return acc;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Per-opcode datapaths
  //////////////////////////////////////////////////////////////////////
  assign shamt   = req.b[shamt_w-1:0];
  assign xor_val = req.a ^ req.b;

  // Four signed bytes sum to at most 10 bits of range
  assign red_val = sext_byte(req.a[data_w-1:byte_w]) + sext_byte(req.a[byte_w-1:0])
                 + sext_byte(req.b[data_w-1:byte_w]) + sext_byte(req.b[byte_w-1:0]);

  assign sll_val  = req.a << shamt;
  assign sra_val  = $signed(req.a) >>> shamt;  // Sign fill
  assign ror_wide = {req.a, req.a} >> shamt;   // Low half is the rotate

  assign paddsb_val = nibble_sat_add(req.a, req.b);

  assign llb_val = {req.a[data_w-1:byte_w], req.b[byte_w-1:0]};  // Keep a high byte
  assign lhb_val = {req.b[byte_w-1:0], req.a[byte_w-1:0]};       // Keep a low byte

  //////////////////////////////////////////////////////////////////////
  // Result select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    res = '0;
    case (req.op)
      op_xor:    res.value = xor_val;
      op_red:    res.value = red_val;
      op_sll:    res.value = sll_val;
      op_sra:    res.value = sra_val;
      op_ror:    res.value = ror_wide[data_w-1:0];
      op_paddsb: res.value = paddsb_val;
      op_llb:    res.value = llb_val;
      op_lhb:    res.value = lhb_val;
      default:   res.value = '0;   // Arithmetic or invalid
    endcase
    res.ovf = 1'b0;  // No V flag source here
  end

endmodule

// File: source/result_flag_merge.sv
// Result select, output register and condition-flag register
// One cycle of latency, accepts a request every cycle, no back-pressure
// error pulses with out_valid for opcodes C..F and the result is then zero
// Flags are a held level and only change for opcodes whose class allows it

`timescale 1ns/10ps

module result_flag_merge
  import alu_pkg::*;
  import flag_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,
  input  alu_op_e           op,
  input  unit_res_s         arith_res,
  input  unit_res_s         logic_res,
  output logic              out_valid,
  output logic [data_w-1:0] result,
  output logic              error,
  output alu_flags_s        flags
);

  unit_res_s   sel_res;     // Chosen unit output
  logic        sel_err;     // Opcode not recognised
  alu_flags_s  next_flags;  // Flags as computed from sel_res
  flag_class_e fclass;

  //////////////////////////////////////////////////////////////////////
  // Unit select
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    sel_err = 1'b0;
    case (op)
      op_add, op_sub, op_lw, op_sw: sel_res = arith_res;
      op_xor, op_red, op_sll, op_sra, op_ror,
      op_paddsb, op_llb, op_lhb:    sel_res = logic_res;
      default: begin
        sel_res = '0;   // C..F
        sel_err = 1'b1;
      end
    endcase
  end

  assign next_flags.z = (sel_res.value == '0);
  assign next_flags.v = sel_res.ovf;
  assign next_flags.n = sel_res.value[data_w-1];
  assign fclass       = flag_class_of(op);

  //////////////////////////////////////////////////////////////////////
  // Output and flag registers
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      error     <= 1'b0;
      result    <= '0;
      flags     <= '0;
    end else begin
      out_valid <= in_valid;              // Pulse that follows the strobe
      error     <= in_valid & sel_err;
      if (in_valid) begin
        result <= sel_res.value;          // Holds while idle
        case (fclass)
          fc_zvn:    flags   <= next_flags;
          fc_z_only: flags.z <= next_flags.z;   // V and N keep their value
          default:   flags   <= flags;
        endcase
      end
    end
  end

  // Decode of an unknown opcode would pick a unit at random
  a_op_known: assert property (@(posedge clk) disable iff (rst)
                               in_valid |-> !$isunknown(op))
    else $error("result_flag_merge: op is X with in_valid high");

  // V may only come from a saturating ADD or SUB
  a_logic_no_ovf: assert property (@(posedge clk) disable iff (rst)
                                   in_valid |-> !logic_res.ovf)
    else $error("result_flag_merge: logic unit raised ovf");

  a_addr_no_ovf: assert property (@(posedge clk) disable iff (rst)
                                  in_valid && (op == op_lw || op == op_sw)
                                  |-> !arith_res.ovf)
    else $error("result_flag_merge: ovf raised on LW/SW address formation");

endmodule

// File: source/alu_execute.sv
// Execute-stage ALU top level
// Request on edge k with in_valid high gives out_valid and result at edge k+1
// The consumer must take the result in its out_valid cycle
// Both units see the same request, only the merge block holds state

`timescale 1ns/10ps

module alu_execute
  import alu_pkg::*;
  import flag_pkg::*;
(
  input  logic              clk,
  input  logic              rst,
  input  logic              in_valid,   // One-cycle strobe
  input  alu_op_e           in_op,
  input  logic [data_w-1:0] in_a,
  input  logic [data_w-1:0] in_b,
  output logic              out_valid,  // One-cycle pulse
  output logic [data_w-1:0] result,
  output logic              error,      // Invalid opcode, with out_valid
  output alu_flags_s        flags       // Held level
);

  alu_req_s  req;        // Shared operand bundle
  unit_res_s arith_res;
  unit_res_s logic_res;

  assign req.op = in_op;
  assign req.a  = in_a;
  assign req.b  = in_b;

  //////////////////////////////////////////////////////////////////////
  // Functional units, side by side
  //////////////////////////////////////////////////////////////////////
  arith_unit u_arith (
    .req (req),
    .res (arith_res)
  );

  logic_shift_unit u_logic (
    .req (req),
    .res (logic_res)
  );

  // Select, register, flags
  result_flag_merge u_merge (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .op        (in_op),
    .arith_res (arith_res),
    .logic_res (logic_res),
    .out_valid (out_valid),
    .result    (result),
    .error     (error),
    .flags     (flags)
  );

endmodule

// File: bench/alu_execute_tb.sv
// Self-checking testbench for the execute-stage ALU
// Table entries, then random ADD/SUB requests, go in back to back, one per clock
// Table flag values assume the entries run in the order listed
// Outputs are sampled on the falling edge, half a cycle after they update

`timescale 1ns/10ps

module alu_execute_tb
  import alu_pkg::*;
  import flag_pkg::*;
();

  localparam int n_tab       = 29;
  localparam int n_rand      = 32;
  localparam int clk_period  = 40;
  localparam int watchdog_ns = (n_tab + n_rand + 20) * clk_period;
  localparam int max_pos     = 2**(data_w-1) - 1;   // Largest signed result
  localparam int min_neg     = -(2**(data_w-1));

  logic              clk;
  logic              rst;
  logic              in_valid;
  alu_op_e           in_op;
  logic [data_w-1:0] in_a;
  logic [data_w-1:0] in_b;
  logic              out_valid;
  logic [data_w-1:0] result;
  logic              error;
  alu_flags_s        flags;

  // Stimulus and expected values per test
  string             name_q[$];
  logic [3:0]        op_q[$];      // Raw code so that C..F can be driven
  logic [data_w-1:0] a_q[$];
  logic [data_w-1:0] b_q[$];
  logic [data_w-1:0] res_q[$];
  logic              err_q[$];
  alu_flags_s        flag_q[$];

  int                pass_count;
  int                fail_count;
  integer            seed;
  logic [data_w-1:0] last_res;     // What the idle cycles must hold
  alu_flags_s        last_flags;

  alu_execute alu_execute_i (
    .clk       (clk),
    .rst       (rst),
    .in_valid  (in_valid),
    .in_op     (in_op),
    .in_a      (in_a),
    .in_b      (in_b),
    .out_valid (out_valid),
    .result    (result),
    .error     (error),
    .flags     (flags)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////
  // Stimulus table and reference model
  ////////////////////////////////////////////////////////////////////
  task automatic add_entry(input string name, input logic [3:0] op,
                           input logic [data_w-1:0] a, input logic [data_w-1:0] b,
                           input logic [data_w-1:0] res, input logic err,
                           input logic [2:0] fl);
    name_q.push_back(name);
    op_q.push_back(op);
    a_q.push_back(a);
    b_q.push_back(b);
    res_q.push_back(res);
    err_q.push_back(err);
    flag_q.push_back(alu_flags_s'(fl));  // Bits are z, v, n
  endtask

  task automatic fill_table();
    add_entry("add_sat_pos", op_add,    16'h7FFF, 16'h0001, 16'h7FFF, 1'b0, 3'b010);
    add_entry("sub_sat_neg", op_sub,    16'h8000, 16'h0001, 16'h8000, 1'b0, 3'b011);
    add_entry("add_plain",   op_add,    16'h1234, 16'h1111, 16'h2345, 1'b0, 3'b000);
    add_entry("sub_zero",    op_sub,    16'h0042, 16'h0042, 16'h0000, 1'b0, 3'b100);
    add_entry("add_neg",     op_add,    16'hFFFE, 16'hFFFF, 16'hFFFD, 1'b0, 3'b001);
    add_entry("sub_sat_pos", op_sub,    16'h7FFF, 16'hFFFF, 16'h7FFF, 1'b0, 3'b010);
    add_entry("xor_zero",    op_xor,    16'h1234, 16'h1234, 16'h0000, 1'b0, 3'b110);
    // N stays low although the result is negative
    add_entry("xor_ones",    op_xor,    16'hA5A5, 16'h5A5A, 16'hFFFF, 1'b0, 3'b010);
    add_entry("add_sat_neg", op_add,    16'h8000, 16'hFFFF, 16'h8000, 1'b0, 3'b011);
    add_entry("sll",         op_sll,    16'h0001, 16'h0004, 16'h0010, 1'b0, 3'b011);
    add_entry("sll_out",     op_sll,    16'h8000, 16'h0001, 16'h0000, 1'b0, 3'b111);
    add_entry("sra_neg",     op_sra,    16'h8000, 16'h0004, 16'hF800, 1'b0, 3'b011);
    add_entry("sra_pos",     op_sra,    16'h7000, 16'h0003, 16'h0E00, 1'b0, 3'b011);
    add_entry("ror",         op_ror,    16'h1234, 16'h0004, 16'h4123, 1'b0, 3'b011);
    add_entry("ror_hi_b",    op_ror,    16'h8001, 16'hFFF1, 16'hC000, 1'b0, 3'b011);
    add_entry("red",         op_red,    16'h0102, 16'h0304, 16'h000A, 1'b0, 3'b011);
    add_entry("red_neg",     op_red,    16'h80FF, 16'hFF80, 16'hFEFE, 1'b0, 3'b011);
    add_entry("paddsb",      op_paddsb, 16'h1234, 16'h1111, 16'h2345, 1'b0, 3'b011);
    add_entry("paddsb_sat",  op_paddsb, 16'h783F, 16'h182F, 16'h785E, 1'b0, 3'b011);
    add_entry("llb",         op_llb,    16'hABCD, 16'h1234, 16'hAB34, 1'b0, 3'b011);
    add_entry("lhb",         op_lhb,    16'hABCD, 16'h1234, 16'h34CD, 1'b0, 3'b011);
    add_entry("lw",          op_lw,     16'h1001, 16'h0010, 16'h1020, 1'b0, 3'b011);
    add_entry("sw_wrap",     op_sw,     16'hFFFF, 16'h0001, 16'h0000, 1'b0, 3'b011);
    add_entry("sw_no_sat",   op_sw,     16'h7FFF, 16'h4000, 16'hFFFE, 1'b0, 3'b011);
    add_entry("invalid_c",   4'hC,      16'h1234, 16'h5678, 16'h0000, 1'b1, 3'b011);
    add_entry("invalid_d",   4'hD,      16'hFFFF, 16'hFFFF, 16'h0000, 1'b1, 3'b011);
    add_entry("invalid_e",   4'hE,      16'h8000, 16'h0001, 16'h0000, 1'b1, 3'b011);
    add_entry("invalid_f",   4'hF,      16'h0000, 16'h0000, 16'h0000, 1'b1, 3'b011);
    add_entry("add_after",   op_add,    16'h0001, 16'h0001, 16'h0002, 1'b0, 3'b000);
  endtask

  // Exact signed sum or difference clamped to the data width
  // Top bit of the returned value is V
  function automatic logic [data_w:0] sat_add_sub(input logic is_sub,
                                                  input logic [data_w-1:0] a,
                                                  input logic [data_w-1:0] b);
    int s;
    if (is_sub)
      s = int'($signed(a)) - int'($signed(b));
    else
      s = int'($signed(a)) + int'($signed(b));
    if (s > max_pos)
      return {1'b1, 1'b0, {(data_w-1){1'b1}}};   // Clamp high
    if (s < min_neg)
      return {1'b1, 1'b1, {(data_w-1){1'b0}}};   // Clamp low
    return {1'b0, s[data_w-1:0]};
  endfunction

  task automatic fill_random();
    logic [31:0]       ra;
    logic [31:0]       rb;
    logic [31:0]       rsel;
    logic [data_w:0]   model;
    logic [data_w-1:0] val;
    logic              is_sub;
    for (int k = 0; k < n_rand; k++) begin
      ra     = $random(seed);
      rb     = $random(seed);
      rsel   = $random(seed);
      is_sub = rsel[0];
      model  = sat_add_sub(is_sub, ra[data_w-1:0], rb[data_w-1:0]);
      val    = model[data_w-1:0];
      // ADD and SUB write all three flags
      add_entry($sformatf("rand_%s_%0d", is_sub ? "sub" : "add", k),
                is_sub ? op_sub : op_add, ra[data_w-1:0], rb[data_w-1:0], val, 1'b0,
                {val == '0, model[data_w], val[data_w-1]});
    end
  endtask

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////
  task automatic report_result(input string name, input bit ok);
    if (ok) begin
      pass_count++;
      $display("PASS %s", name);
    end else begin
      fail_count++;
      $display("FAIL %s", name);
    end
  endtask

  task automatic check_entry(input int idx);
    bit ok;
    ok = 1'b1;
    assert (out_valid === 1'b1)
      else begin
        $display("FAILED %s: out_valid expected 1, actual %b", name_q[idx], out_valid);
        ok = 1'b0;
      end
    assert (result === res_q[idx])
      else begin
        $display("FAILED %s: result expected %h, actual %h", name_q[idx], res_q[idx], result);
        ok = 1'b0;
      end
    assert (error === err_q[idx])
      else begin
        $display("FAILED %s: error expected %b, actual %b", name_q[idx], err_q[idx], error);
        ok = 1'b0;
      end
    assert (flags === flag_q[idx])
      else begin
        $display("FAILED %s: flags zvn expected %b, actual %b", name_q[idx], flag_q[idx],
                 flags);
        ok = 1'b0;
      end
    report_result(name_q[idx], ok);
  endtask

  // Idle or just out of reset with expected values from the caller
  task automatic check_quiet(input string name, input logic [data_w-1:0] exp_res,
                             input alu_flags_s exp_flags);
    bit ok;
    ok = 1'b1;
    assert (out_valid === 1'b0 && error === 1'b0)
      else begin
        $display("FAILED %s: out_valid/error expected 0/0, actual %b/%b", name, out_valid,
                 error);
        ok = 1'b0;
      end
    assert (result === exp_res)
      else begin
        $display("FAILED %s: result expected %h, actual %h", name, exp_res, result);
        ok = 1'b0;
      end
    assert (flags === exp_flags)
      else begin
        $display("FAILED %s: flags zvn expected %b, actual %b", name, exp_flags, flags);
        ok = 1'b0;
      end
    report_result(name, ok);
  endtask

  ////////////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////////////
  initial begin
    rst        = 1'b1;
    in_valid   = 1'b0;
    in_op      = op_add;
    in_a       = '0;
    in_b       = '0;
    pass_count = 0;
    fail_count = 0;
    seed       = 32'h6582;
    fill_table();
    fill_random();

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    @(negedge clk);
    check_quiet("reset", '0, '0);

    // Entry i goes in while entry i-1 is checked
    for (int i = 0; i <= name_q.size(); i++) begin
      @(posedge clk);
      if (i < name_q.size()) begin
        in_valid <= 1'b1;
        in_op    <= alu_op_e'(op_q[i]);
        in_a     <= a_q[i];
        in_b     <= b_q[i];
      end else begin
        in_valid <= 1'b0;          // Operands change while idle
        in_op    <= op_add;
        in_a     <= 16'hDEAD;
        in_b     <= 16'hBEEF;
      end
      if (i > 0) begin
        @(negedge clk);
        check_entry(i - 1);
      end
    end

    last_res   = res_q[$];
    last_flags = flag_q[$];
    for (int c = 0; c < 3; c++) begin
      @(posedge clk);
      @(negedge clk);
      check_quiet($sformatf("idle_hold_%0d", c), last_res, last_flags);
    end

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

  // Watchdog sized from the number of tests
  initial begin
    #(watchdog_ns);
    $display("Timeout: run did not complete within %0d ns", watchdog_ns);
    $display("Errors found");
    $finish;
  end

endmodule

// File: compile.f
common/alu_pkg.sv
common/flag_pkg.sv
source/arith_unit.sv
source/logic_shift_unit.sv
source/result_flag_merge.sv
source/alu_execute.sv
bench/alu_execute_tb.sv

// File: Makefile
# Verilator simulation of the execute-stage ALU

VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = alu_execute_tb
FILELIST  = compile.f
OBJ_DIR   = obj_dir
PASS_MSG  = No errors

.PHONY: sim clean

# Fails unless the pass line appears in the simulation output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
